//--- dsp_tx_pkg.sv
package dsp_tx_pkg;

   // Datapath widths
   localparam int SAMPLE_W = 32;
   localparam int BB_W     = 18;
   localparam int PHASE_W  = 32;
   localparam int DAC_W    = 24;

   localparam int CIC_ORDER = 4;
   localparam int CIC_ACC_W = 36;    // 18 + 3*log2(64) with margin

   localparam int CORDIC_W      = 24;
   localparam int CORDIC_STAGES = 22;
   localparam int UPC_LATENCY   = CORDIC_STAGES + 2;  // Input reg, stages, multiplier reg

   typedef logic        [SAMPLE_W-1:0] sample_word_t;  // I high, Q low
   typedef logic signed [BB_W-1:0]     bb_t;
   typedef logic        [PHASE_W-1:0]  phase_t;        // 2^32 is one turn
   typedef logic signed [DAC_W-1:0]    dac_word_t;

   typedef struct packed {
      bb_t i;
      bb_t q;
   } iq_t;

   // A quarter turn in rotator angle units
   localparam logic [CORDIC_W-1:0] CORDIC_QUARTER = 1 << (CORDIC_W - 2);

   // atan(2^-k) scaled so that 2^24 is one turn
   localparam logic [CORDIC_W-1:0] CORDIC_ATAN [CORDIC_STAGES] = '{
      24'd2097152, 24'd1238021, 24'd654136, 24'd332050, 24'd166669,
      24'd83416,   24'd41718,   24'd20860,  24'd10430,  24'd5215,
      24'd2608,    24'd1304,    24'd652,    24'd326,    24'd163,
      24'd81,      24'd41,      24'd20,     24'd10,     24'd5,
      24'd3,       24'd1
   };

endpackage

//--- tx_regs_pkg.sv
package tx_regs_pkg;

   // Register map
   localparam logic [7:0] TX_BASE       = 8'd0;
   localparam logic [7:0] REG_PHASE_INC = 8'd0;
   localparam logic [7:0] REG_SCALE     = 8'd1;   // scale_i high, scale_q low
   localparam logic [7:0] REG_RATE      = 8'd2;

   typedef logic signed [15:0] scale_t;          // Q1.14
   typedef logic        [7:0]  rate_t;

   // 1.0 in Q1.14
   localparam scale_t SCALE_ONE = 16'sd16384;

   // Decoded configuration as seen by the datapath
   typedef struct packed {
      dsp_tx_pkg::phase_t phase_inc;
      scale_t             scale_i;
      scale_t             scale_q;
      rate_t              interp_rate;
      logic [2:0]         rate_log2;
   } tx_cfg_t;

endpackage

//--- tx_settings.sv
`timescale 1ns/1ps

module tx_settings (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 set_stb_i,
   input  logic [7:0]           set_addr_i,
   input  logic [31:0]          set_data_i,
   output tx_regs_pkg::tx_cfg_t cfg_o
);

   logic wr_phase;
   logic wr_scale;
   logic wr_rate;

   // Position of the highest set bit
   function automatic logic [2:0] rate_to_log2(input tx_regs_pkg::rate_t rate);
      logic [2:0] lg;
      lg = '0;
      for (int b = 1; b < 8; b++) begin
         if (rate[b]) begin
            lg = 3'(b);
         end
      end
      return lg;
   endfunction

   assign wr_phase = set_stb_i &&
                     (set_addr_i == 8'(tx_regs_pkg::TX_BASE + tx_regs_pkg::REG_PHASE_INC));
   assign wr_scale = set_stb_i &&
                     (set_addr_i == 8'(tx_regs_pkg::TX_BASE + tx_regs_pkg::REG_SCALE));
   assign wr_rate  = set_stb_i &&
                     (set_addr_i == 8'(tx_regs_pkg::TX_BASE + tx_regs_pkg::REG_RATE));

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_o.phase_inc   <= '0;
         cfg_o.scale_i     <= tx_regs_pkg::SCALE_ONE;
         cfg_o.scale_q     <= tx_regs_pkg::SCALE_ONE;
         cfg_o.interp_rate <= 8'd1;
         cfg_o.rate_log2   <= '0;
      end else begin
         if (wr_phase) begin
            cfg_o.phase_inc <= set_data_i;
         end
         if (wr_scale) begin
            cfg_o.scale_i <= set_data_i[31:16];
            cfg_o.scale_q <= set_data_i[15:0];
         end
         if (wr_rate) begin
            cfg_o.interp_rate <= set_data_i[7:0];
            cfg_o.rate_log2   <= rate_to_log2(set_data_i[7:0]);  // Shift for the CIC gain
         end
      end
   end

   // Only powers of two keep the CIC gain an exact shift
   a_rate_pow2: assert property (@(posedge clk) disable iff (rst)
      wr_rate |-> (set_data_i[7:0] inside {8'd1, 8'd2, 8'd4, 8'd8, 8'd16, 8'd32, 8'd64}))
      else $error("tx_settings: rate %0d is not a power of two up to 64", set_data_i[7:0]);

endmodule

//--- tx_strober.sv
`timescale 1ns/1ps

module tx_strober (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  tx_regs_pkg::rate_t  rate_i,
   output logic                cic_stb_o,
   output logic                strobe_o
);

   tx_regs_pkg::rate_t count;

   // Pulse at zero, so the first one lands on the first run cycle
   assign cic_stb_o = run_i && (count == '0);

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         count <= '0;
      end else if (count == '0) begin
         count <= rate_i - 8'd1;   // Rate 1 reloads to 0
      end else begin
         count <= count - 8'd1;
      end
   end

   // Sample request runs one cycle behind the CIC strobe for timing
   always_ff @(posedge clk) begin
      if (rst) begin
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= cic_stb_o;
      end
   end

   a_no_strobe_idle: assert property (@(posedge clk) disable iff (rst)
      !$past(run_i) |-> !strobe_o)
      else $error("tx_strober: strobe_o high after an idle cycle");

endmodule

//--- cic_interp.sv
`timescale 1ns/1ps

module cic_interp (
   input  logic            clk,
   input  logic            rst,
   input  logic            run_i,
   input  logic            stb_i,
   input  logic [2:0]      rate_log2_i,
   input  dsp_tx_pkg::bb_t data_i,
   output dsp_tx_pkg::bb_t data_o
);

   typedef logic signed [dsp_tx_pkg::CIC_ACC_W-1:0] acc_t;

   acc_t       comb_dly [dsp_tx_pkg::CIC_ORDER];  // Last input of each comb
   acc_t       comb     [dsp_tx_pkg::CIC_ORDER];
   acc_t       integ    [dsp_tx_pkg::CIC_ORDER];
   acc_t       int_in;
   acc_t       scaled;
   logic       stb_d;
   logic       fits;
   logic [4:0] shift;

   // Combs at the input rate, outputs held between strobes
   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         for (int k = 0; k < dsp_tx_pkg::CIC_ORDER; k++) begin
            comb_dly[k] <= '0;
            comb[k]     <= '0;
         end
      end else if (stb_i) begin
         comb_dly[0] <= acc_t'(data_i);
         comb[0]     <= acc_t'(data_i) - comb_dly[0];
         for (int k = 1; k < dsp_tx_pkg::CIC_ORDER; k++) begin
            comb_dly[k] <= comb[k-1];
            comb[k]     <= comb[k-1] - comb_dly[k];
         end
      end
   end

   // Each comb result enters the integrators once, zeros in between
   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         stb_d <= 1'b0;
      end else begin
         stb_d <= stb_i;
      end
   end

   assign int_in = stb_d ? comb[dsp_tx_pkg::CIC_ORDER-1] : '0;

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         for (int k = 0; k < dsp_tx_pkg::CIC_ORDER; k++) begin
            integ[k] <= '0;
         end
      end else begin
         integ[0] <= integ[0] + int_in;
         for (int k = 1; k < dsp_tx_pkg::CIC_ORDER; k++) begin
            integ[k] <= integ[k] + integ[k-1];
         end
      end
   end

   // Gain is rate cubed
   assign shift  = {rate_log2_i, 1'b0} + 5'(rate_log2_i);
   assign scaled = integ[dsp_tx_pkg::CIC_ORDER-1] >>> shift;
   assign fits   = (&scaled[dsp_tx_pkg::CIC_ACC_W-1:dsp_tx_pkg::BB_W-1]) ||
                   !(|scaled[dsp_tx_pkg::CIC_ACC_W-1:dsp_tx_pkg::BB_W-1]);

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         data_o <= '0;
      end else if (fits) begin
         data_o <= scaled[dsp_tx_pkg::BB_W-1:0];
      end else begin
         // Clip to full scale
         data_o <= {scaled[dsp_tx_pkg::CIC_ACC_W-1],
                    {(dsp_tx_pkg::BB_W-1){!scaled[dsp_tx_pkg::CIC_ACC_W-1]}}};
      end
   end

endmodule

//--- tx_upconverter.sv
`timescale 1ns/1ps

module tx_upconverter (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  dsp_tx_pkg::phase_t    phase_inc_i,
   input  tx_regs_pkg::scale_t   scale_i_i,
   input  tx_regs_pkg::scale_t   scale_q_i,
   input  dsp_tx_pkg::iq_t       iq_i,
   output dsp_tx_pkg::dac_word_t tx_i_o,
   output dsp_tx_pkg::dac_word_t tx_q_o
);

   // Two guard bits above the rotator word for the CORDIC gain
   typedef logic signed [dsp_tx_pkg::CORDIC_W+1:0] cw_t;
   typedef logic signed [dsp_tx_pkg::CORDIC_W-1:0] ang_t;

   dsp_tx_pkg::phase_t phase;
   cw_t                xs [dsp_tx_pkg::CORDIC_STAGES+1];
   cw_t                ys [dsp_tx_pkg::CORDIC_STAGES+1];
   ang_t               zs [dsp_tx_pkg::CORDIC_STAGES];
   cw_t                x_in;
   cw_t                y_in;
   ang_t               z_in;
   dsp_tx_pkg::bb_t    rot_i;
   dsp_tx_pkg::bb_t    rot_q;
   logic signed [35:0] prod_i;
   logic signed [35:0] prod_q;

   // Back to 18 bits, clipped
   function automatic dsp_tx_pkg::bb_t sat_bb(input cw_t v);
      cw_t t;
      t = v >>> (dsp_tx_pkg::CORDIC_W - dsp_tx_pkg::BB_W);
      if (&t[dsp_tx_pkg::CORDIC_W+1:dsp_tx_pkg::BB_W-1] ||
          !(|t[dsp_tx_pkg::CORDIC_W+1:dsp_tx_pkg::BB_W-1])) begin
         return t[dsp_tx_pkg::BB_W-1:0];
      end
      return {t[dsp_tx_pkg::CORDIC_W+1], {(dsp_tx_pkg::BB_W-1){!t[dsp_tx_pkg::CORDIC_W+1]}}};
   endfunction

   // NCO
   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc_i;
      end
   end

   assign x_in = cw_t'($signed({iq_i.i, {(dsp_tx_pkg::CORDIC_W-dsp_tx_pkg::BB_W){1'b0}}}));
   assign y_in = cw_t'($signed({iq_i.q, {(dsp_tx_pkg::CORDIC_W-dsp_tx_pkg::BB_W){1'b0}}}));
   assign z_in = phase[dsp_tx_pkg::PHASE_W-1 -: dsp_tx_pkg::CORDIC_W];

   // Input register with quadrant pre-rotation
   always_ff @(posedge clk) begin
      if (rst) begin
         xs[0] <= '0;
         ys[0] <= '0;
         zs[0] <= '0;
      end else begin
         case (z_in[dsp_tx_pkg::CORDIC_W-1 -: 2])
            2'b01: begin                 // 90 to 180 degrees
               xs[0] <= -y_in;
               ys[0] <= x_in;
               zs[0] <= z_in - dsp_tx_pkg::CORDIC_QUARTER;
            end
            2'b10: begin                 // -180 to -90 degrees
               xs[0] <= y_in;
               ys[0] <= -x_in;
               zs[0] <= z_in + dsp_tx_pkg::CORDIC_QUARTER;
            end
            default: begin
               xs[0] <= x_in;
               ys[0] <= y_in;
               zs[0] <= z_in;
            end
         endcase
      end
   end

   for (genvar k = 0; k < dsp_tx_pkg::CORDIC_STAGES; k++) begin : g_stage
      always_ff @(posedge clk) begin
         if (rst) begin
            xs[k+1] <= '0;
            ys[k+1] <= '0;
         end else if (zs[k][dsp_tx_pkg::CORDIC_W-1]) begin  // Negative angle left
            xs[k+1] <= xs[k] + (ys[k] >>> k);
            ys[k+1] <= ys[k] - (xs[k] >>> k);
         end else begin
            xs[k+1] <= xs[k] - (ys[k] >>> k);
            ys[k+1] <= ys[k] + (xs[k] >>> k);
         end
      end

      // Last stage needs no residual angle
      if (k < dsp_tx_pkg::CORDIC_STAGES - 1) begin : g_angle
         always_ff @(posedge clk) begin
            if (rst) begin
               zs[k+1] <= '0;
            end else if (zs[k][dsp_tx_pkg::CORDIC_W-1]) begin
               zs[k+1] <= zs[k] + dsp_tx_pkg::CORDIC_ATAN[k];
            end else begin
               zs[k+1] <= zs[k] - dsp_tx_pkg::CORDIC_ATAN[k];
            end
         end
      end
   end

   assign rot_i = sat_bb(xs[dsp_tx_pkg::CORDIC_STAGES]);
   assign rot_q = sat_bb(ys[dsp_tx_pkg::CORDIC_STAGES]);

   // Registered scaling multipliers
   always_ff @(posedge clk) begin
      if (rst) begin
         prod_i <= '0;
         prod_q <= '0;
      end else begin
         prod_i <= rot_i * scale_i_i;
         prod_q <= rot_q * scale_q_i;
      end
   end

   assign tx_i_o = prod_i[28:5];   // Q1.14 scale leaves 9 fraction bits
   assign tx_q_o = prod_q[28:5];

   a_phase_idle: assert property (@(posedge clk) disable iff (rst)
      !$past(run_i) |-> (phase == '0))
      else $error("tx_upconverter: NCO phase not cleared after idle");

endmodule

//--- tx_dsp_core.sv
`timescale 1ns/1ps

module tx_dsp_core (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     set_stb_i,
   input  logic [7:0]               set_addr_i,
   input  logic [31:0]              set_data_i,
   input  dsp_tx_pkg::sample_word_t sample_i,
   input  logic                     run_i,
   output logic                     strobe_o,
   output dsp_tx_pkg::dac_word_t    tx_i_o,
   output dsp_tx_pkg::dac_word_t    tx_q_o
);

   tx_regs_pkg::tx_cfg_t cfg;
   logic                 cic_stb;
   dsp_tx_pkg::iq_t      bb_in;
   dsp_tx_pkg::iq_t      iq_cic;

   // 16-bit halves into the 18-bit datapath
   assign bb_in.i = {sample_i[31:16], 2'b00};
   assign bb_in.q = {sample_i[15:0], 2'b00};

   tx_settings i_tx_settings (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cfg_o      (cfg)
   );

   tx_strober i_tx_strober (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .rate_i    (cfg.interp_rate),
      .cic_stb_o (cic_stb),
      .strobe_o  (strobe_o)
   );

   cic_interp i_cic_interp_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .stb_i       (cic_stb),
      .rate_log2_i (cfg.rate_log2),
      .data_i      (bb_in.i),
      .data_o      (iq_cic.i)
   );

   cic_interp i_cic_interp_q (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .stb_i       (cic_stb),
      .rate_log2_i (cfg.rate_log2),
      .data_i      (bb_in.q),
      .data_o      (iq_cic.q)
   );

   tx_upconverter i_tx_upconverter (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .phase_inc_i (cfg.phase_inc),
      .scale_i_i   (cfg.scale_i),
      .scale_q_i   (cfg.scale_q),
      .iq_i        (iq_cic),
      .tx_i_o      (tx_i_o),
      .tx_q_o      (tx_q_o)
   );

endmodule

//--- tb_tx_dsp_core.sv
`timescale 1ns/1ps

module tb_tx_dsp_core;

   localparam real CORDIC_GAIN    = 1.6468;
   localparam int  TIMEOUT_CYCLES = 20000;  // All tests together need about 2000
   localparam int  STROBE_LIMIT   = 200;    // Longest gap at rate 64, with margin
   localparam int  FLUSH          = dsp_tx_pkg::UPC_LATENCY + 2;
   localparam int  IN_I           = 2000;   // Small enough to fit the 24-bit DAC slice
   localparam int  IN_Q           = -1500;

   logic                     clk;
   logic                     rst;
   logic                     set_stb_i;
   logic [7:0]               set_addr_i;
   logic [31:0]              set_data_i;
   dsp_tx_pkg::sample_word_t sample_i = '0;
   logic                     run_i;
   logic                     strobe_o;
   dsp_tx_pkg::dac_word_t    tx_i_o;
   dsp_tx_pkg::dac_word_t    tx_q_o;

   logic        src_random;
   logic [31:0] src_const;
   logic [31:0] lcg_state = 32'h1434;
   int          cycles = 0;
   int          value_errors = 0;
   int          other_errors = 0;

   tx_dsp_core i_tx_dsp_core (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .sample_i   (sample_i),
      .run_i      (run_i),
      .strobe_o   (strobe_o),
      .tx_i_o     (tx_i_o),
      .tx_q_o     (tx_q_o)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // DAC word for a constant input at phase 0
   function automatic real expected_dac(input int in16, input int scale);
      return $itor(in16) * 4.0 * CORDIC_GAIN * $itor(scale) / 32.0;
   endfunction

   // 0 to 3 for the dominant axis, counter-clockwise from +I
   function automatic int quadrant_of(input int i, input int q);
      int ai;
      int aq;
      ai = (i < 0) ? -i : i;
      aq = (q < 0) ? -q : q;
      if (ai >= aq) begin
         return (i >= 0) ? 0 : 2;
      end
      return (q >= 0) ? 1 : 3;
   endfunction

   // Upstream source, new word after each sample request
   always @(posedge clk) begin
      if (!src_random) begin
         sample_i <= src_const;
      end else if (strobe_o) begin
         lcg_state <= lcg_next(lcg_state);
         sample_i  <= lcg_next(lcg_state);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run stopped by timeout after %0d cycles", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic report_value(input string name, input int got, input real exp);
      value_errors++;
      $display("ERR %0t %s: got %0d, expected %0.1f", $time, name, got, exp);
   endtask

   task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
      @(posedge clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= tx_regs_pkg::TX_BASE + offset;
      set_data_i <= data;
      @(posedge clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic configure(input logic [31:0] phase_inc, input int scale_i,
                            input int scale_q, input int rate);
      write_reg(tx_regs_pkg::REG_PHASE_INC, phase_inc);
      write_reg(tx_regs_pkg::REG_SCALE, {16'(scale_i), 16'(scale_q)});
      write_reg(tx_regs_pkg::REG_RATE, 32'(rate));
   endtask

   task automatic start_run();
      @(posedge clk);
      run_i <= 1'b1;
   endtask

   task automatic stop_and_flush();
      @(posedge clk);
      run_i <= 1'b0;
      repeat (FLUSH) @(posedge clk);
   endtask

   // Cycles until the next strobe_o pulse
   task automatic next_strobe(output int gap);
      gap = 0;
      do begin
         @(negedge clk);
         gap++;
      end while (!strobe_o && gap < STROBE_LIMIT);
      if (!strobe_o) begin
         other_errors++;
         $display("No strobe_o pulse within %0d cycles at %0t", STROBE_LIMIT, $time);
      end
   endtask

   task automatic idle_after_reset();
      for (int c = 0; c < 40; c++) begin
         @(negedge clk);
         if (strobe_o !== 1'b0) report_value("strobe_o", strobe_o, 0.0);
         if (tx_i_o !== '0) report_value("tx_i_o", tx_i_o, 0.0);
         if (tx_q_o !== '0) report_value("tx_q_o", tx_q_o, 0.0);
      end
   endtask

   task automatic strobe_spacing(input int rate);
      int gap;
      src_random <= 1'b1;
      configure(32'd0, 16384, 16384, rate);
      start_run();
      next_strobe(gap);
      if (gap != 2) report_value("first strobe_o delay", gap, 2.0);  // Run edge, then strobe
      repeat (4) begin
         next_strobe(gap);
         if (gap != rate) report_value("strobe_o spacing", gap, $itor(rate));
      end
      stop_and_flush();
   endtask

   // Constant input, phase 0, compare both DAC words after the CIC settles
   task automatic check_dc(input int scale_i, input int scale_q, input int rate);
      real exp_i;
      real exp_q;
      real tol_i;
      real tol_q;
      src_random <= 1'b0;
      src_const  <= {16'(IN_I), 16'(IN_Q)};
      configure(32'd0, scale_i, scale_q, rate);
      start_run();
      repeat (16 * rate + dsp_tx_pkg::UPC_LATENCY + 8) @(posedge clk);
      exp_i = expected_dac(IN_I, scale_i);
      exp_q = expected_dac(IN_Q, scale_q);
      tol_i = 0.005 * ((exp_i < 0.0) ? -exp_i : exp_i) + 2.0;
      tol_q = 0.005 * ((exp_q < 0.0) ? -exp_q : exp_q) + 2.0;
      repeat (4) begin
         @(negedge clk);
         if ($itor(tx_i_o) - exp_i > tol_i || exp_i - $itor(tx_i_o) > tol_i)
            report_value("tx_i_o", tx_i_o, exp_i);
         if ($itor(tx_q_o) - exp_q > tol_q || exp_q - $itor(tx_q_o) > tol_q)
            report_value("tx_q_o", tx_q_o, exp_q);
      end
      stop_and_flush();
   endtask

   task automatic dc_gain(input int rate);
      check_dc(16384, 16384, rate);
   endtask

   task automatic independent_scaling();
      check_dc(-8192, 16384, 1);
   endtask

   task automatic rotation();
      int  q_now;
      int  q_prev;
      real mag;
      real exp_mag;
      src_random <= 1'b0;
      src_const  <= {16'(IN_I), 16'd0};
      configure(32'h4000_0000, 16384, 16384, 1);   // Quarter turn per clock
      start_run();
      repeat (16 + dsp_tx_pkg::UPC_LATENCY + 8) @(posedge clk);
      exp_mag = expected_dac(IN_I, 16384);
      @(negedge clk);
      q_prev = quadrant_of(tx_i_o, tx_q_o);
      repeat (12) begin
         @(negedge clk);
         mag = $sqrt($itor(tx_i_o) * $itor(tx_i_o) + $itor(tx_q_o) * $itor(tx_q_o));
         if (mag > 1.01 * exp_mag || mag < 0.99 * exp_mag)
            report_value("tx magnitude", $rtoi(mag), exp_mag);
         q_now = quadrant_of(tx_i_o, tx_q_o);
         if (q_now != (q_prev + 1) % 4) report_value("quadrant", q_now, (q_prev + 1) % 4);
         q_prev = q_now;
      end
      stop_and_flush();
   endtask

   task automatic stop_behavior();
      src_random <= 1'b1;
      configure(32'h1000_0000, 16384, 16384, 4);
      start_run();
      repeat (100) @(posedge clk);
      @(posedge clk);
      run_i <= 1'b0;
      for (int k = 0; k < FLUSH; k++) begin
         @(negedge clk);
         if (k > 0 && strobe_o !== 1'b0) report_value("strobe_o", strobe_o, 0.0);
      end
      @(negedge clk);
      if (tx_i_o !== '0) report_value("tx_i_o", tx_i_o, 0.0);
      if (tx_q_o !== '0) report_value("tx_q_o", tx_q_o, 0.0);
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      run_i      = 1'b0;
      src_random = 1'b0;
      src_const  = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      idle_after_reset();
      strobe_spacing(1);
      strobe_spacing(4);
      strobe_spacing(64);
      dc_gain(1);
      dc_gain(8);
      rotation();
      independent_scaling();
      stop_behavior();

      $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- sources.f
dsp_tx_pkg.sv
tx_regs_pkg.sv
tx_settings.sv
tx_strober.sv
cic_interp.sv
tx_upconverter.sv
tx_dsp_core.sv
tb_tx_dsp_core.sv

//--- Bender.yml
package:
  name: tx_dsp_core

sources:
  - dsp_tx_pkg.sv
  - tx_regs_pkg.sv
  - tx_settings.sv
  - tx_strober.sv
  - cic_interp.sv
  - tx_upconverter.sv
  - tx_dsp_core.sv
  - target: simulation
    files:
      - tb_tx_dsp_core.sv
